//--- include/bbox_defs.svh
/* Fixed-point and pipeline sizes shared by every file of the bounding-box stage.
   Coordinates are signed, with BBOX_RADIX fraction bits out of BBOX_SIGFIG. */
`ifndef BBOX_DEFS_SVH
`define BBOX_DEFS_SVH

// Word width of every coordinate and colour channel
`define BBOX_SIGFIG 24

// Fraction bits inside a coordinate word
`define BBOX_RADIX 10

// Vertices per triangle
`define BBOX_VERTS 3

// Axes per vertex, x then y then z
`define BBOX_AXES 3

// Colour channels per triangle
`define BBOX_COLORS 3

// Register stages between input and output
`define BBOX_PIPE_DEPTH 3

`endif

//--- src/bbox_pkg.sv
/* Types of the bounding-box stage and the MSAA rounding mask.
   Sub-sample codes that are not one-hot round like 1x. */
`include "bbox_defs.svh"

package bbox_pkg;

    // Signed fixed-point coordinate
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // Triangle, vertex index first, then axis (0 x, 1 y, 2 z)
    typedef coord_t tri_t [`BBOX_VERTS-1:0][`BBOX_AXES-1:0];

    // Unsigned colour channels
    typedef logic [`BBOX_SIGFIG-1:0] color_t [`BBOX_COLORS-1:0];

    // Box corners, 0 lower-left and 1 upper-right, each as x then y
    typedef coord_t box_t [1:0][1:0];

    // One-hot MSAA code, bit 3 for 1x down to bit 0 for 64x
    typedef logic [3:0] ss_t;

    // Mask that floors a coordinate onto the sub-sample grid
    function automatic coord_t ss_mask(ss_t ss);
        int unsigned clear_bits;
        case (ss)
            // 4x keeps half a pixel
            4'b0100: clear_bits = `BBOX_RADIX - 1;
            // 16x keeps a quarter pixel
            4'b0010: clear_bits = `BBOX_RADIX - 2;
            // 64x keeps an eighth of a pixel
            4'b0001: clear_bits = `BBOX_RADIX - 3;
            // 1x and every illegal code snap to whole pixels
            default: clear_bits = `BBOX_RADIX;
        endcase
        // Ones above the kept fraction, zeros below
        return {`BBOX_SIGFIG{1'b1}} << clear_bits;
    endfunction

endpackage

//--- src/bbox_pipe.sv
/* Delay line of DEPTH registers for any payload type, DEPTH of 1 or more.
   All stages hold while halt_n is low and clear to zero on reset. */
`timescale 1ns/100ps

module bbox_pipe #(
    parameter type T = logic,
    parameter int DEPTH = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic halt_n,
    input  T     d,
    output T     q
);

    // Stage 0 is nearest the input
    T stage [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Zero every leaf of every stage
            stage <= '{default: '0};
        end else if (halt_n) begin
            stage[0] <= d;
            // Shift the rest one step towards the output
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Last stage drives the output
    assign q = stage[DEPTH-1];

endmodule

//--- src/bbox_axis.sv
/* One axis of the bounding box, purely combinational.
   extent is the screen size on this axis and must be positive; ss is a held level. */
`timescale 1ns/100ps

module bbox_axis (
    input  bbox_pkg::coord_t v0,
    input  bbox_pkg::coord_t v1,
    input  bbox_pkg::coord_t v2,
    input  bbox_pkg::coord_t extent,
    input  bbox_pkg::ss_t    ss,
    output bbox_pkg::coord_t lo,
    output bbox_pkg::coord_t hi,
    output logic             on_screen
);

    // Raw extremes of the three vertices
    bbox_pkg::coord_t min_v;
    bbox_pkg::coord_t max_v;
    // Extremes floored onto the sub-sample grid
    bbox_pkg::coord_t min_r;
    bbox_pkg::coord_t max_r;
    // Grid mask for the current MSAA code
    bbox_pkg::coord_t mask;

    // Minimum over three, signed compare
    always_comb begin
        min_v = v0;
        if (v1 < min_v) begin
            min_v = v1;
        end
        if (v2 < min_v) begin
            min_v = v2;
        end
    end

    // Maximum over three
    always_comb begin
        max_v = v0;
        if (v1 > max_v) begin
            max_v = v1;
        end
        if (v2 > max_v) begin
            max_v = v2;
        end
    end

    assign mask = bbox_pkg::ss_mask(ss);

    // Floor both ends, clearing the low fraction bits
    // Sign bit is kept so negative values round towards minus infinity
    assign min_r = min_v & mask;
    assign max_r = max_v & mask;

    // Box touches the screen on this axis
    // Upper end not left of zero and lower end before the edge
    assign on_screen = (max_r >= 0) && (min_r < extent);

    // Lower end clamped up to the origin
    always_comb begin
        if (min_r < 0) begin
            lo = '0;
        end else begin
            lo = min_r;
        end
    end

    // Upper end clamped down to the screen size
    always_comb begin
        if (max_r > extent) begin
            hi = extent;
        end else begin
            hi = max_r;
        end
    end

endmodule

//--- src/bbox_join.sv
/* Joins the x and y axis results into one box and a valid bit.
   Both leave after BBOX_PIPE_DEPTH enabled clock edges. */
`timescale 1ns/100ps
`include "bbox_defs.svh"

module bbox_join (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             halt_n,
    input  logic             valid_in,
    input  bbox_pkg::coord_t x_lo,
    input  bbox_pkg::coord_t x_hi,
    input  bbox_pkg::coord_t y_lo,
    input  bbox_pkg::coord_t y_hi,
    input  logic             x_on,
    input  logic             y_on,
    output bbox_pkg::box_t   box_out,
    output logic             valid_out
);

    // Box before the pipeline
    bbox_pkg::box_t box_d;
    // Valid before the pipeline
    logic           valid_d;

    // Lower-left corner
    assign box_d[0][0] = x_lo;
    assign box_d[0][1] = y_lo;
    // Upper-right corner
    assign box_d[1][0] = x_hi;
    assign box_d[1][1] = y_hi;

    // Rejected unless the input is valid and both axes reach the screen
    assign valid_d = valid_in & x_on & y_on;

    // Box delay line
    bbox_pipe #(
        .T     (bbox_pkg::box_t),
        .DEPTH (`BBOX_PIPE_DEPTH)
    ) box_pipe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .halt_n (halt_n),
        .d      (box_d),
        .q      (box_out)
    );

    // Valid delay line, same depth so box and valid stay aligned
    bbox_pipe #(
        .T     (logic),
        .DEPTH (`BBOX_PIPE_DEPTH)
    ) valid_pipe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .halt_n (halt_n),
        .d      (valid_d),
        .q      (valid_out)
    );

endmodule

//--- src/bbox_top.sv
/* Bounding-box stage of the rasterizer, latency BBOX_PIPE_DEPTH enabled edges.
   screen_x, screen_y and ss must be held steady while triangles are in flight. */
`timescale 1ns/100ps
`include "bbox_defs.svh"

module bbox_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt_n,
    input  bbox_pkg::tri_t     tri_in,
    input  bbox_pkg::color_t   color_in,
    input  logic               valid_in,
    input  bbox_pkg::coord_t   screen_x,
    input  bbox_pkg::coord_t   screen_y,
    input  bbox_pkg::ss_t      ss,
    output bbox_pkg::tri_t     tri_out,
    output bbox_pkg::color_t   color_out,
    output bbox_pkg::box_t     box_out,
    output logic               valid_out
);

    // Clamped x bounds and x on-screen flag
    bbox_pkg::coord_t x_lo;
    bbox_pkg::coord_t x_hi;
    logic             x_on;
    // Clamped y bounds and y on-screen flag
    bbox_pkg::coord_t y_lo;
    bbox_pkg::coord_t y_hi;
    logic             y_on;

    // X axis, axis index 0 of each vertex
    bbox_axis axis_x (
        .v0        (tri_in[0][0]),
        .v1        (tri_in[1][0]),
        .v2        (tri_in[2][0]),
        .extent    (screen_x),
        .ss        (ss),
        .lo        (x_lo),
        .hi        (x_hi),
        .on_screen (x_on)
    );

    // Y axis, axis index 1
    bbox_axis axis_y (
        .v0        (tri_in[0][1]),
        .v1        (tri_in[1][1]),
        .v2        (tri_in[2][1]),
        .extent    (screen_y),
        .ss        (ss),
        .lo        (y_lo),
        .hi        (y_hi),
        .on_screen (y_on)
    );

    // Box assembly and its pipeline
    bbox_join join_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .valid_in  (valid_in),
        .x_lo      (x_lo),
        .x_hi      (x_hi),
        .y_lo      (y_lo),
        .y_hi      (y_hi),
        .x_on      (x_on),
        .y_on      (y_on),
        .box_out   (box_out),
        .valid_out (valid_out)
    );

    // Triangle travels alongside its box, z included
    bbox_pipe #(
        .T     (bbox_pkg::tri_t),
        .DEPTH (`BBOX_PIPE_DEPTH)
    ) tri_pipe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .halt_n (halt_n),
        .d      (tri_in),
        .q      (tri_out)
    );

    // Colour travels alongside too
    bbox_pipe #(
        .T     (bbox_pkg::color_t),
        .DEPTH (`BBOX_PIPE_DEPTH)
    ) color_pipe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .halt_n (halt_n),
        .d      (color_in),
        .q      (color_out)
    );

endmodule

//--- test/bbox_chk.sv
/* Output invariants of bbox_top, bound into every instance.
   Box ordering and screen limits only hold while valid_out is high. */
`timescale 1ns/100ps

module bbox_chk (
    input logic             clk,
    input logic             rst_n,
    input bbox_pkg::coord_t screen_x,
    input bbox_pkg::coord_t screen_y,
    input bbox_pkg::box_t   box_out,
    input logic             valid_out
);

    // Lower corner never past the upper one
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (box_out[0][0] <= box_out[1][0]) && (box_out[0][1] <= box_out[1][1]))
        else $error("valid box has its lower corner above its upper corner");

    // Upper corner clamped to the screen
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (box_out[1][0] <= screen_x) && (box_out[1][1] <= screen_y))
        else $error("valid box extends past the screen");

    assert property (@(posedge clk) !rst_n |-> !valid_out)
        else $error("valid_out high while in reset");

endmodule

bind bbox_top bbox_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .screen_x  (screen_x),
    .screen_y  (screen_y),
    .box_out   (box_out),
    .valid_out (valid_out)
);

//--- test/bbox_tb.sv
/* Table-driven testbench for bbox_top on a 64 x 48 pixel screen.
   A model queue of row indices tracks the three pipeline stages and only
   shifts on edges with halt_n high; box is compared only when valid is expected. */
`timescale 1ns/100ps
`include "bbox_defs.svh"

module bbox_tb;

    localparam int N_ROWS = 24;
    localparam bbox_pkg::ss_t SS_1X  = 4'b1000;
    localparam bbox_pkg::ss_t SS_4X  = 4'b0100;
    localparam bbox_pkg::ss_t SS_16X = 4'b0010;
    localparam bbox_pkg::ss_t SS_64X = 4'b0001;
    // Two bits set, must round like 1x
    localparam bbox_pkg::ss_t SS_BAD = 4'b0110;

    logic             clk;
    logic             rst_n;
    logic             halt_n;
    bbox_pkg::tri_t   tri_in;
    bbox_pkg::color_t color_in;
    logic             valid_in;
    bbox_pkg::coord_t screen_x;
    bbox_pkg::coord_t screen_y;
    bbox_pkg::ss_t    ss;
    bbox_pkg::tri_t   tri_out;
    bbox_pkg::color_t color_out;
    bbox_pkg::box_t   box_out;
    logic             valid_out;

    // Stimulus and expected columns
    bbox_pkg::tri_t   tab_tri   [N_ROWS];
    bbox_pkg::color_t tab_color [N_ROWS];
    logic             tab_vld   [N_ROWS];
    bbox_pkg::ss_t    tab_ss    [N_ROWS];
    logic             tab_halt  [N_ROWS];
    bbox_pkg::box_t   tab_box   [N_ROWS];
    logic             tab_ev    [N_ROWS];
    int               n_rows = 0;
    int               seed = 41310;
    // Row index held by each stage, output stage first, -1 for reset contents
    int               inflight [$];

    bbox_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .valid_in  (valid_in),
        .screen_x  (screen_x),
        .screen_y  (screen_y),
        .ss        (ss),
        .tri_out   (tri_out),
        .color_out (color_out),
        .box_out   (box_out),
        .valid_out (valid_out)
    );

    // Pixel value to fixed point, truncating towards zero
    function automatic bbox_pkg::coord_t fx(real v);
        integer raw;
        raw = $rtoi(v * real'(1 << `BBOX_RADIX));
        return raw[`BBOX_SIGFIG-1:0];
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic add_row(input real x0, input real y0, input real x1, input real y1,
                           input real x2, input real y2, input real z,
                           input logic vld, input bbox_pkg::ss_t s, input logic hlt,
                           input real bx0, input real by0, input real bx1, input real by1,
                           input logic ev);
        logic [31:0] rnd;
        if (n_rows >= N_ROWS) begin
            $display("Stimulus table holds more rows than N_ROWS");
            stop_run();
        end
        tab_tri[n_rows][0][0] = fx(x0);
        tab_tri[n_rows][0][1] = fx(y0);
        tab_tri[n_rows][1][0] = fx(x1);
        tab_tri[n_rows][1][1] = fx(y1);
        tab_tri[n_rows][2][0] = fx(x2);
        tab_tri[n_rows][2][1] = fx(y2);
        // z differs per vertex so a swapped vertex shows up
        for (int k = 0; k < `BBOX_VERTS; k++) begin
            tab_tri[n_rows][k][2] = fx(z + k);
        end
        for (int c = 0; c < `BBOX_COLORS; c++) begin
            rnd = $random(seed);
            tab_color[n_rows][c] = rnd[`BBOX_SIGFIG-1:0];
        end
        tab_vld[n_rows]       = vld;
        tab_ss[n_rows]        = s;
        tab_halt[n_rows]      = hlt;
        tab_box[n_rows][0][0] = fx(bx0);
        tab_box[n_rows][0][1] = fx(by0);
        tab_box[n_rows][1][0] = fx(bx1);
        tab_box[n_rows][1][1] = fx(by1);
        tab_ev[n_rows]        = ev;
        n_rows++;
    endtask

    // Stalled cycle, its inputs must never enter the pipeline
    task automatic add_halt_row();
        add_row(1.0, 1.0, 2.0, 2.0, 3.0, 3.0, 9.0, 1'b1, SS_1X, 1'b0, 0, 0, 0, 0, 1'b0);
    endtask

    // Empty slot used to drain the pipeline
    task automatic add_idle_row();
        add_row(0, 0, 0, 0, 0, 0, 0, 1'b0, SS_1X, 1'b1, 0, 0, 0, 0, 1'b0);
    endtask

    task automatic load_table();
        // Box at each grid, then an illegal code
        add_row(10.7, 5.3, 20.9, 12.8, 15.2, 30.6, 1.0, 1'b1, SS_1X, 1'b1,
                10.0, 5.0, 20.0, 30.0, 1'b1);
        add_row(10.7, 5.3, 20.9, 12.8, 15.2, 30.6, 2.0, 1'b1, SS_4X, 1'b1,
                10.5, 5.0, 20.5, 30.5, 1'b1);
        add_halt_row();
        add_halt_row();
        add_halt_row();
        add_row(10.7, 5.3, 20.9, 12.8, 15.2, 30.6, 3.0, 1'b1, SS_16X, 1'b1,
                10.5, 5.25, 20.75, 30.5, 1'b1);
        add_row(10.7, 5.3, 20.9, 12.8, 15.2, 30.6, 4.0, 1'b1, SS_64X, 1'b1,
                10.625, 5.25, 20.875, 30.5, 1'b1);
        add_row(10.7, 5.3, 20.9, 12.8, 15.2, 30.6, 5.0, 1'b1, SS_BAD, 1'b1,
                10.0, 5.0, 20.0, 30.0, 1'b1);
        // Left, bottom and right edge crossings
        add_row(-5.5, 10.2, 12.3, 14.7, 3.1, 20.4, 6.0, 1'b1, SS_1X, 1'b1,
                0.0, 10.0, 12.0, 20.0, 1'b1);
        add_row(8.4, -3.3, 16.6, 7.7, 25.1, 2.2, 7.0, 1'b1, SS_1X, 1'b1,
                8.0, 0.0, 25.0, 7.0, 1'b1);
        add_row(50.5, 10.0, 70.2, 15.5, 60.0, 25.9, 8.0, 1'b1, SS_1X, 1'b1,
                50.0, 10.0, 64.0, 25.0, 1'b1);
        // Stall with the pipeline full
        add_halt_row();
        add_halt_row();
        // Top edge, all four edges, then a box that only touches x = 0
        add_row(30.3, 40.1, 35.8, 55.6, 40.0, 44.4, 10.0, 1'b1, SS_1X, 1'b1,
                30.0, 40.0, 40.0, 48.0, 1'b1);
        add_row(-2.0, -2.0, 70.0, 60.0, 10.0, 10.0, 11.0, 1'b1, SS_1X, 1'b1,
                0.0, 0.0, 64.0, 48.0, 1'b1);
        add_row(-5.0, 5.0, 0.0, 10.0, -2.0, 8.0, 12.0, 1'b1, SS_1X, 1'b1,
                0.0, 5.0, 0.0, 10.0, 1'b1);
        // Right of, above, left of and below the screen
        add_row(64.0, 10.0, 70.0, 12.0, 80.0, 20.0, 13.0, 1'b1, SS_1X, 1'b1,
                0, 0, 0, 0, 1'b0);
        add_row(10.0, 48.5, 20.0, 50.0, 15.0, 60.0, 14.0, 1'b1, SS_1X, 1'b1,
                0, 0, 0, 0, 1'b0);
        add_row(-10.0, 5.0, -3.0, 8.0, -0.5, 12.0, 15.0, 1'b1, SS_1X, 1'b1,
                0, 0, 0, 0, 1'b0);
        add_row(5.0, -8.0, 10.0, -4.0, 15.0, -0.2, 16.0, 1'b1, SS_1X, 1'b1,
                0, 0, 0, 0, 1'b0);
        // On-screen triangle with valid_in low
        add_row(10.7, 5.3, 20.9, 12.8, 15.2, 30.6, 17.0, 1'b0, SS_1X, 1'b1,
                0, 0, 0, 0, 1'b0);
        add_idle_row();
        add_idle_row();
        add_idle_row();
    endtask

    task automatic check_tri(input bbox_pkg::tri_t exp, input bbox_pkg::tri_t act);
        for (int v = 0; v < `BBOX_VERTS; v++) begin
            for (int a = 0; a < `BBOX_AXES; a++) begin
                if (act[v][a] !== exp[v][a]) begin
                    $display("FAIL %0t tri_out[%0d][%0d] expected %h got %h",
                             $time, v, a, exp[v][a], act[v][a]);
                    stop_run();
                end
            end
        end
    endtask

    task automatic check_color(input bbox_pkg::color_t exp, input bbox_pkg::color_t act);
        for (int c = 0; c < `BBOX_COLORS; c++) begin
            if (act[c] !== exp[c]) begin
                $display("FAIL %0t color_out[%0d] expected %h got %h",
                         $time, c, exp[c], act[c]);
                stop_run();
            end
        end
    endtask

    task automatic check_box(input bbox_pkg::box_t exp, input bbox_pkg::box_t act);
        for (int k = 0; k < 2; k++) begin
            for (int a = 0; a < 2; a++) begin
                if (act[k][a] !== exp[k][a]) begin
                    $display("FAIL %0t box_out[%0d][%0d] expected %h got %h",
                             $time, k, a, exp[k][a], act[k][a]);
                    stop_run();
                end
            end
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t valid_out expected %b got %b", $time, exp, act);
            stop_run();
        end
    endtask

    // Compare all outputs with the row held in the output stage
    task automatic check_outputs(input int idx);
        bbox_pkg::tri_t   exp_tri;
        bbox_pkg::color_t exp_color;
        bbox_pkg::box_t   exp_box;
        exp_tri   = '{default: '0};
        exp_color = '{default: '0};
        exp_box   = '{default: '0};
        if (idx < 0) begin
            check_box(exp_box, box_out);
            check_valid(1'b0, valid_out);
        end else begin
            exp_tri   = tab_tri[idx];
            exp_color = tab_color[idx];
            check_valid(tab_ev[idx], valid_out);
            if (tab_ev[idx]) begin
                check_box(tab_box[idx], box_out);
            end
        end
        check_tri(exp_tri, tri_out);
        check_color(exp_color, color_out);
    endtask

    task automatic drive_row(input int i);
        tri_in   = tab_tri[i];
        color_in = tab_color[i];
        valid_in = tab_vld[i];
        ss       = tab_ss[i];
        halt_n   = tab_halt[i];
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog sized from the table, reset included in the margin
    initial begin
        #((N_ROWS + 20) * 10);
        $display("Timeout, the stimulus table did not finish in time");
        stop_run();
    end

    initial begin
        rst_n    = 1'b0;
        halt_n   = 1'b1;
        tri_in   = '{default: '0};
        color_in = '{default: '0};
        valid_in = 1'b0;
        screen_x = fx(64.0);
        screen_y = fx(48.0);
        ss       = SS_1X;
        load_table();
        if (n_rows != N_ROWS) begin
            $display("Stimulus table has %0d rows, %0d expected", n_rows, N_ROWS);
            stop_run();
        end
        repeat (`BBOX_PIPE_DEPTH) inflight.push_back(-1);
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            drive_row(i);
            @(posedge clk);
            #1;
            // Enabled edge captured row i and moved every stage on
            if (tab_halt[i]) begin
                inflight.push_back(i);
                void'(inflight.pop_front());
            end
            check_outputs(inflight[0]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
src/bbox_pkg.sv
src/bbox_pipe.sv
src/bbox_axis.sv
src/bbox_join.sv
src/bbox_top.sv
test/bbox_chk.sv
test/bbox_tb.sv

//--- Makefile
TOP = bbox_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
